// File: masku_pkg.sv
// Shared widths and encodings of the mask unit
// Lane datapath is fixed at 64 bits; the beat width is NrLanes times that
// MLOGIC always works on 1-bit elements, whatever vsew says

`default_nettype none

package masku_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Lane datapath width
  localparam int unsigned ElenWidth = 64;

  // Element counts, used for vl and remaining counts
  typedef logic [15:0] vlen_t;

  // Instruction ID
  typedef logic [2:0] vid_t;

  // Beat index within one instruction
  typedef logic [11:0] beat_t;

  ////////////////////
  // Encodings
  ////////////////////

  // Element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // Supported operations
  typedef enum logic {
    MERGE  = 1'b0,
    MLOGIC = 1'b1
  } masku_op_e;

  // Log2 of the element width in bits
  function automatic logic [2:0] ew_log2(masku_op_e op, vsew_e vsew);
    if (op == MLOGIC) begin
      return 3'd0;
    end
    return 3'd3 + 3'(vsew);
  endfunction

endpackage

`default_nettype wire

// File: masku_beat_if.sv
// Per-beat instruction state shared between control, enable generators and blend
// NrLanes must be a power of two
// elems is derived here so every stage agrees on the elements per beat

`default_nettype none

interface masku_beat_if #(
  parameter int unsigned NrLanes = 2
);
  import masku_pkg::*;

  localparam int unsigned W = NrLanes * ElenWidth;

  // Current instruction, from the controller
  logic      active;
  masku_op_e op;
  vsew_e     vsew;
  logic      vm;
  vid_t      id;
  vlen_t     remaining;
  beat_t     beat;

  // Beat handshake and queue state, from the blend stage
  logic fire;
  logic drained;

  // Elements in one full beat, W/E
  vlen_t elems;
  assign elems = vlen_t'(W >> ew_log2(op, vsew));

  modport ctrl (output active, op, vsew, vm, id, remaining, beat, input fire, drained, elems);
  modport tail (input op, vsew, remaining, elems);
  modport pred (input active, op, vsew, vm, remaining, fire, elems);
  modport blend (input active, id, beat, output fire, drained);

endinterface

`default_nettype wire

// File: masku_ctrl.sv
// Instruction control of the mask unit
// Holds a single instruction; a new request waits for the done pulse
// vl must be nonzero and its beat count must fit in beat_t

`default_nettype none

module masku_ctrl #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request channel
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  masku_pkg::masku_op_e req_op_i,
  input  masku_pkg::vsew_e     req_vsew_i,
  input  logic                 req_vm_i,
  input  masku_pkg::vlen_t     req_vl_i,
  input  masku_pkg::vid_t      req_id_i,
  // Completion
  output logic                 done_o,
  output masku_pkg::vid_t      done_id_o,
  // Beat state toward the datapath
  masku_beat_if.ctrl           beat_o
);
  import masku_pkg::*;

  localparam int unsigned W = NrLanes * ElenWidth;

  // Instruction register
  logic      busy_q;
  masku_op_e op_q;
  vsew_e     vsew_q;
  logic      vm_q;
  vid_t      id_q;
  vlen_t     remaining_q;
  beat_t     beat_q;

  logic req_hs;
  logic finish;

  ////////////////////
  // Acceptance
  ////////////////////

  assign req_ready_o = !busy_q;
  assign req_hs      = req_valid_i && req_ready_o;

  // All beats issued and every result has left the queue
  assign finish = busy_q && (remaining_q == '0) && beat_o.drained;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      op_q        <= MERGE;
      vsew_q      <= EW8;
      vm_q        <= 1'b1;
      id_q        <= '0;
      remaining_q <= '0;
      beat_q      <= '0;
      done_o      <= 1'b0;
    end else begin
      done_o <= finish;
      if (req_hs) begin
        busy_q      <= 1'b1;
        op_q        <= req_op_i;
        vsew_q      <= req_vsew_i;
        vm_q        <= req_vm_i;
        id_q        <= req_id_i;
        remaining_q <= req_vl_i;
        beat_q      <= '0;
      end else if (finish) begin
        busy_q <= 1'b0;
      end else if (beat_o.fire) begin
        // One full beat of elements leaves, saturating on the tail beat
        remaining_q <= (remaining_q > beat_o.elems) ? remaining_q - beat_o.elems : '0;
        beat_q      <= beat_q + 1'b1;
      end
    end
  end

  // ID travels with the done pulse
  always_ff @(posedge clk_i) begin
    if (finish) begin
      done_id_o <= id_q;
    end
  end

  ////////////////////
  // Beat state
  ////////////////////

  // Active only while beats are still to be issued
  assign beat_o.active    = busy_q && (remaining_q != '0);
  assign beat_o.op        = op_q;
  assign beat_o.vsew      = vsew_q;
  assign beat_o.vm        = vm_q;
  assign beat_o.id        = id_q;
  assign beat_o.remaining = remaining_q;
  assign beat_o.beat      = beat_q;

  // No second request slips in before the current one reports done
  a_one_insn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_hs |=> !req_ready_o until done_o);

  // Accepted vl is nonzero and its beats fit the beat index
  a_req_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_hs |-> (req_vl_i != '0) &&
      ((32'(req_vl_i) << ew_log2(req_op_i, req_vsew_i)) <= (W << $bits(beat_t))));

endmodule

`default_nettype wire

// File: masku_tail_gen.sv
// Tail enable of the current beat
// Purely combinational; bits of elements at or above vl are cleared
// Data is laid out sequentially, element j in bits j*E up to j*E+E-1

`default_nettype none

module masku_tail_gen #(
  parameter int unsigned NrLanes = 2
) (
  // Current instruction state
  masku_beat_if.tail                              beat_i,
  // One enable bit per datapath bit
  output logic [NrLanes*masku_pkg::ElenWidth-1:0] tail_en_o
);
  import masku_pkg::*;

  localparam int unsigned W = NrLanes * ElenWidth;

  // Elements of this beat that still lie below vl
  vlen_t      valid_elems;
  // Bits per element, as a shift
  logic [2:0] log2_e;

  assign log2_e = ew_log2(beat_i.op, beat_i.vsew);

  // Full beat unless this is the tail
  assign valid_elems = (beat_i.remaining < beat_i.elems) ? beat_i.remaining : beat_i.elems;

  ////////////////////
  // Expansion
  ////////////////////

  // Each bit belongs to element i >> log2_e
  always_comb begin
    for (int unsigned i = 0; i < W; i++) begin
      tail_en_o[i] = vlen_t'(i >> log2_e) < valid_elems;
    end
  end

endmodule

`default_nettype wire

// File: masku_predicate_expand.sv
// Mask word consumption and per-bit predicate enable
// A mask word stays on the mask channel until it is used up or the instruction ends
// MLOGIC and vm set both give an all-ones predicate and need no mask word
// Beats are aligned in the mask word, so the pointer lands exactly on W

`default_nettype none

module masku_predicate_expand #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Current instruction state and beat handshake
  masku_beat_if.pred                              beat_i,
  // Mask channel
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] mask_i,
  input  logic                                    mask_valid_i,
  output logic                                    mask_ready_o,
  // Predicate toward the blend stage
  output logic [NrLanes*masku_pkg::ElenWidth-1:0] pred_en_o,
  output logic                                    pred_valid_o
);
  import masku_pkg::*;

  localparam int unsigned W    = NrLanes * ElenWidth;
  localparam int unsigned PtrW = $clog2(W);

  // Bit pointer into the held mask word
  logic [PtrW-1:0] ptr_q;
  logic [PtrW:0]   ptr_sum;
  logic [PtrW-1:0] bit_idx;
  logic [2:0]      log2_e;

  logic masked;
  logic last_beat;
  logic word_done;
  logic release_word;

  // Mask bits only matter for a masked MERGE in progress
  assign masked = beat_i.active && !beat_i.vm && (beat_i.op == MERGE);
  assign log2_e = ew_log2(beat_i.op, beat_i.vsew);

  ////////////////////
  // Word release
  ////////////////////

  assign ptr_sum   = {1'b0, ptr_q} + (PtrW + 1)'(beat_i.elems);
  assign word_done = ptr_sum[PtrW];
  // This fire issues the final elements
  assign last_beat = beat_i.remaining <= beat_i.elems;

  assign release_word = masked && beat_i.fire && (word_done || last_beat);
  assign mask_ready_o = release_word;

  // The held word is the one on the channel
  assign pred_valid_o = !masked || mask_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (!beat_i.active) begin
      ptr_q <= '0;
    end else if (masked && beat_i.fire) begin
      ptr_q <= release_word ? '0 : ptr_sum[PtrW-1:0];
    end
  end

  ////////////////////
  // Expansion
  ////////////////////

  // Mask bit of element i >> log2_e, repeated over the element's E bits
  always_comb begin
    pred_en_o = '1;
    bit_idx   = '0;
    for (int unsigned i = 0; i < W; i++) begin
      bit_idx = ptr_q + PtrW'(i >> log2_e);
      if (masked) begin
        pred_en_o[i] = mask_i[bit_idx];
      end
    end
  end

  // Blend never fires a masked beat without a mask word
  a_fire_has_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_i.fire && masked |-> mask_valid_i);

endmodule

`default_nettype wire

// File: masku_blend.sv
// Blend stage and result queue
// A beat fires only with both operands, the predicate and a free queue slot
// The queue does not pass a result through in the cycle it is written

`default_nettype none

module masku_blend #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Beat handshake and instruction state
  masku_beat_if.blend                             beat_i,
  // Enables from the two generators
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] tail_en_i,
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] pred_en_i,
  input  logic                                    pred_valid_i,
  // Computed operand
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] opa_i,
  input  logic                                    opa_valid_i,
  output logic                                    opa_ready_o,
  // Old destination value
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] opb_i,
  input  logic                                    opb_valid_i,
  output logic                                    opb_ready_o,
  // Result channel
  output logic [NrLanes*masku_pkg::ElenWidth-1:0] res_wdata_o,
  output masku_pkg::beat_t                        res_beat_o,
  output masku_pkg::vid_t                         res_id_o,
  output logic                                    res_valid_o,
  input  logic                                    res_ready_i
);
  import masku_pkg::*;

  localparam int unsigned W    = NrLanes * ElenWidth;
  localparam int unsigned IdxW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  // Queue storage
  logic [W-1:0] data_q [ResultQueueDepth];
  beat_t        beat_q [ResultQueueDepth];
  vid_t         id_q   [ResultQueueDepth];

  // Queue control
  logic [IdxW-1:0] wr_ptr_q;
  logic [IdxW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  logic         full;
  logic         fire;
  logic         pop;
  logic [W-1:0] bit_en;
  logic [W-1:0] blended;

  // Circular increment
  function automatic logic [IdxW-1:0] next_ptr(logic [IdxW-1:0] ptr);
    return (ptr == IdxW'(ResultQueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // Beat fire
  ////////////////////

  assign full = cnt_q == CntW'(ResultQueueDepth);
  assign fire = beat_i.active && opa_valid_i && opb_valid_i && pred_valid_i && !full;

  assign beat_i.fire    = fire;
  assign beat_i.drained = cnt_q == '0;
  assign opa_ready_o    = fire;
  assign opb_ready_o    = fire;

  // Element takes a only below vl and with its mask bit set
  assign bit_en  = tail_en_i & pred_en_i;
  assign blended = (opa_i & bit_en) | (opb_i & ~bit_en);

  ////////////////////
  // Result queue
  ////////////////////

  assign res_valid_o = cnt_q != '0;
  assign pop         = res_valid_o && res_ready_i;

  assign res_wdata_o = data_q[rd_ptr_q];
  assign res_beat_o  = beat_q[rd_ptr_q];
  assign res_id_o    = id_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (fire) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      cnt_q <= cnt_q + CntW'(fire) - CntW'(pop);
    end
  end

  // Blended word, tagged with its beat index
  always_ff @(posedge clk_i) begin
    if (fire) begin
      data_q[wr_ptr_q] <= blended;
      beat_q[wr_ptr_q] <= beat_i.beat;
      id_q[wr_ptr_q]   <= beat_i.id;
    end
  end

  // Never pushed while full
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntW'(ResultQueueDepth));

  // Never popped while empty
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q == '0 |=> cnt_q <= CntW'(1));

endmodule

`default_nettype wire

// File: masku.sv
// Mask unit top level, predicated and tail-aware writeback
// One instruction at a time; done_o closes each one with its ID
// NrLanes must be a power of two

`default_nettype none

module masku #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Request
  input  logic                                    req_valid_i,
  output logic                                    req_ready_o,
  input  masku_pkg::masku_op_e                    req_op_i,
  input  masku_pkg::vsew_e                        req_vsew_i,
  input  logic                                    req_vm_i,
  input  masku_pkg::vlen_t                        req_vl_i,
  input  masku_pkg::vid_t                         req_id_i,
  // Operand a
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] opa_i,
  input  logic                                    opa_valid_i,
  output logic                                    opa_ready_o,
  // Operand b
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] opb_i,
  input  logic                                    opb_valid_i,
  output logic                                    opb_ready_o,
  // Mask words
  input  logic [NrLanes*masku_pkg::ElenWidth-1:0] mask_i,
  input  logic                                    mask_valid_i,
  output logic                                    mask_ready_o,
  // Results
  output logic [NrLanes*masku_pkg::ElenWidth-1:0] res_wdata_o,
  output masku_pkg::beat_t                        res_beat_o,
  output masku_pkg::vid_t                         res_id_o,
  output logic                                    res_valid_o,
  input  logic                                    res_ready_i,
  // Completion
  output logic                                    done_o,
  output masku_pkg::vid_t                         done_id_o
);
  import masku_pkg::*;

  localparam int unsigned W = NrLanes * ElenWidth;

  // Enables toward the blend stage
  logic [W-1:0] tail_en;
  logic [W-1:0] pred_en;
  logic         pred_valid;

  masku_beat_if #(.NrLanes(NrLanes)) beat_if ();

  masku_ctrl #(.NrLanes(NrLanes)) i_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_op_i, .req_vsew_i, .req_vm_i, .req_vl_i, .req_id_i,
    .done_o, .done_id_o,
    .beat_o (beat_if.ctrl)
  );

  masku_tail_gen #(.NrLanes(NrLanes)) i_tail_gen (
    .beat_i    (beat_if.tail),
    .tail_en_o (tail_en)
  );

  masku_predicate_expand #(.NrLanes(NrLanes)) i_predicate_expand (
    .clk_i, .rst_ni,
    .beat_i       (beat_if.pred),
    .mask_i, .mask_valid_i, .mask_ready_o,
    .pred_en_o    (pred_en),
    .pred_valid_o (pred_valid)
  );

  masku_blend #(
    .NrLanes          (NrLanes),
    .ResultQueueDepth (ResultQueueDepth)
  ) i_blend (
    .clk_i, .rst_ni,
    .beat_i       (beat_if.blend),
    .tail_en_i    (tail_en),
    .pred_en_i    (pred_en),
    .pred_valid_i (pred_valid),
    .opa_i, .opa_valid_i, .opa_ready_o,
    .opb_i, .opb_valid_i, .opb_ready_o,
    .res_wdata_o, .res_beat_o, .res_id_o, .res_valid_o, .res_ready_i
  );

endmodule

`default_nettype wire

// File: tb_masku.sv
// Testbench of the mask unit with two lanes, so one beat is 128 bits
// Operands are always valid once an instruction is set up; only res_ready_i stalls
// Mask words hold at most 2 per instruction and a and b at most 32 beats

`default_nettype none

module tb_masku;
  timeunit 1ns;
  timeprecision 1ps;
  import masku_pkg::*;

  localparam int unsigned NrLanes = 2;
  localparam int unsigned W       = NrLanes * ElenWidth;
  localparam int          Timeout = 2000;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_valid_i, req_ready_o, req_vm_i;
  masku_op_e req_op_i;
  vsew_e     req_vsew_i;
  vlen_t     req_vl_i;
  vid_t      req_id_i;
  logic [W-1:0] opa_i, opb_i, mask_i, res_wdata_o;
  logic opa_valid_i, opa_ready_o, opb_valid_i, opb_ready_o;
  logic mask_valid_i, mask_ready_o, res_valid_o, res_ready_i, done_o;
  beat_t res_beat_o;
  vid_t  res_id_o, done_id_o;

  // Stimulus store, filled per instruction
  logic [W-1:0] a_mem [32];
  logic [W-1:0] b_mem [32];
  logic [W-1:0] mask_mem [8];

  // Expected results, in beat order
  logic [W-1:0] exp_word_q [$];
  beat_t        exp_beat_q [$];
  vid_t         exp_id_q [$];
  int           mask_rel_q [$];
  vid_t         exp_done_id;
  string        test_name = "reset";

  int word_errs = 0;
  int beat_errs = 0;
  int id_errs = 0;
  int other_errs = 0;
  int ops_taken = 0;
  int res_seen = 0;
  int done_seen = 0;
  int insn_count = 0;
  logic insn_open = 1'b0;
  logic bp_on = 1'b0;
  logic [255:0] stall_pat;
  logic [7:0] stall_idx = '0;

  masku #(.NrLanes(NrLanes), .ResultQueueDepth(2)) i_dut (.*);

  always #50 clk_i = ~clk_i;

  // Result sink, stalls follow a fixed pattern when enabled
  always @(posedge clk_i) begin
    res_ready_i <= bp_on ? stall_pat[stall_idx] : 1'b1;
    stall_idx   <= stall_idx + 1'b1;
  end

  ////////////////////
  // Reference and checks
  ////////////////////

  // Element takes a below vl with its mask bit set; MLOGIC has 1-bit, unmasked elements
  function automatic logic [W-1:0] ref_beat(masku_op_e op, vsew_e vsew, logic vm, int vl,
                                            int k, logic [W-1:0] a, logic [W-1:0] b);
    logic [W-1:0] r;
    int e;
    int g;
    e = (op == MLOGIC) ? 1 : (8 << int'(vsew));
    for (int i = 0; i < W; i++) begin
      g = k * (W / e) + i / e;
      if (g < vl && (op == MLOGIC || vm || mask_mem[g / W][g % W])) begin
        r[i] = a[i];
      end else begin
        r[i] = b[i];
      end
    end
    return r;
  endfunction

  task automatic check_word(string name, logic [W-1:0] exp, logic [W-1:0] act);
    if (act !== exp) begin
      word_errs++;
      $display("mismatch %s word: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_beat(string name, beat_t exp, beat_t act);
    if (act !== exp) begin
      beat_errs++;
      $display("mismatch %s beat: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_id(string name, vid_t exp, vid_t act);
    if (act !== exp) begin
      id_errs++;
      $display("mismatch %s id: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_other(string what);
    other_errs++;
    $display("error in %s: %s", test_name, what);
  endtask

  task automatic finish_run();
    int total;
    total = word_errs + beat_errs + id_errs + other_errs;
    $display("errors: word %0d, beat %0d, id %0d, other %0d",
             word_errs, beat_errs, id_errs, other_errs);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic stall_abort(string what);
    other_errs++;
    $display("timeout in %s: %s", test_name, what);
    finish_run();
  endtask

  // Compares every result handshake against the expected queue
  always @(posedge clk_i) begin
    if (rst_ni && res_valid_o && res_ready_i) begin
      if (exp_word_q.size() == 0) begin
        report_other("result arrived that was not expected");
      end else begin
        check_word(test_name, exp_word_q.pop_front(), res_wdata_o);
        check_beat(test_name, exp_beat_q.pop_front(), res_beat_o);
        check_id(test_name, exp_id_q.pop_front(), res_id_o);
      end
      res_seen++;
    end
  end

  // Handshake monitor for mask release, request ready and done
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (mask_valid_i && mask_ready_o) begin
        mask_rel_q.push_back(ops_taken);
        if (!opa_ready_o) report_other("mask word released without a beat");
      end
      if (opa_valid_i && opa_ready_o) ops_taken++;
      if (opa_ready_o !== opb_ready_o) report_other("opa_ready_o and opb_ready_o differ");
      if (req_valid_i && req_ready_o) begin
        insn_open = 1'b1;
      end else if (insn_open) begin
        if (done_o) insn_open = 1'b0;
        else if (req_ready_o) report_other("req_ready_o rose before done");
      end
      if (done_o) begin
        done_seen++;
        check_id({test_name, " done"}, exp_done_id, done_id_o);
        if (exp_word_q.size() != 0) report_other("done came before the last result");
      end
    end
  end

  ////////////////////
  // Drivers
  ////////////////////

  task automatic drive_req(masku_op_e op, vsew_e vsew, logic vm, vlen_t vl, vid_t id);
    int tmo;
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_vsew_i  <= vsew;
    req_vm_i    <= vm;
    req_vl_i    <= vl;
    req_id_i    <= id;
    tmo = 0;
    do begin
      @(posedge clk_i);
      if (++tmo > Timeout) stall_abort("request was never accepted");
    end while (!req_ready_o);
    req_valid_i <= 1'b0;
  endtask

  task automatic drive_operands(int n);
    int tmo;
    for (int k = 0; k < n; k++) begin
      opa_i       <= a_mem[k];
      opb_i       <= b_mem[k];
      opa_valid_i <= 1'b1;
      opb_valid_i <= 1'b1;
      tmo = 0;
      do begin
        @(posedge clk_i);
        if (++tmo > Timeout) stall_abort("operand beat was never taken");
      end while (!(opa_ready_o && opb_ready_o));
    end
    opa_valid_i <= 1'b0;
    opb_valid_i <= 1'b0;
  endtask

  task automatic drive_masks(int n);
    int tmo;
    for (int m = 0; m < n; m++) begin
      mask_i       <= mask_mem[m];
      mask_valid_i <= 1'b1;
      tmo = 0;
      do begin
        @(posedge clk_i);
        if (++tmo > Timeout) stall_abort("mask word was never released");
      end while (!mask_ready_o);
    end
    mask_valid_i <= 1'b0;
  endtask

  // One instruction from request to done, with beat count and mask release checks
  task automatic run_insn(string name, masku_op_e op, vsew_e vsew, logic vm, int vl, vid_t id);
    int e;
    int nbeats;
    int nmask;
    int ops_base;
    int res_base;
    int tmo;
    int rel;
    e      = (op == MLOGIC) ? 1 : (8 << int'(vsew));
    nbeats = (vl * e + W - 1) / W;
    nmask  = (op == MERGE && !vm) ? (vl + W - 1) / W : 0;
    test_name = name;
    for (int k = 0; k < nbeats; k++) begin
      a_mem[k] = {$urandom, $urandom, $urandom, $urandom};
      b_mem[k] = {$urandom, $urandom, $urandom, $urandom};
    end
    for (int m = 0; m < nmask; m++) begin
      mask_mem[m] = {$urandom, $urandom, $urandom, $urandom};
    end
    for (int k = 0; k < nbeats; k++) begin
      exp_word_q.push_back(ref_beat(op, vsew, vm, vl, k, a_mem[k], b_mem[k]));
      exp_beat_q.push_back(beat_t'(k));
      exp_id_q.push_back(id);
    end
    exp_done_id = id;
    insn_count++;
    ops_base = ops_taken;
    res_base = res_seen;
    mask_rel_q.delete();
    fork
      drive_req(op, vsew, vm, vlen_t'(vl), id);
      drive_operands(nbeats);
      drive_masks(nmask);
    join
    tmo = 0;
    while (done_seen != insn_count) begin
      @(posedge clk_i);
      if (++tmo > Timeout) stall_abort("done pulse never came");
    end
    // A second pulse would show up within the next cycles
    repeat (2) @(posedge clk_i);
    if (done_seen != insn_count) report_other("done_o pulsed more than once");
    if (res_seen - res_base != nbeats) report_other("wrong number of result beats");
    if (mask_rel_q.size() != nmask) report_other("wrong number of mask words taken");
    foreach (mask_rel_q[m]) begin
      // Word m serves E beats, the last one ends early with the instruction
      rel = ((m + 1) * e - 1 < nbeats - 1) ? (m + 1) * e - 1 : nbeats - 1;
      if (mask_rel_q[m] - ops_base != rel) report_other("mask word released at wrong beat");
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'hf2669a06));
    for (int i = 0; i < 256; i++) begin
      stall_pat[i] = ($urandom % 3) != 0;
    end
    rst_ni       <= 1'b0;
    req_valid_i  <= 1'b0;
    req_op_i     <= MERGE;
    req_vsew_i   <= EW8;
    req_vm_i     <= 1'b1;
    req_vl_i     <= '0;
    req_id_i     <= '0;
    opa_i        <= '0;
    opb_i        <= '0;
    mask_i       <= '0;
    opa_valid_i  <= 1'b0;
    opb_valid_i  <= 1'b0;
    mask_valid_i <= 1'b0;
    res_ready_i  <= 1'b1;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (!req_ready_o || res_valid_o || done_o || opa_ready_o || opb_ready_o || mask_ready_o)
      report_other("outputs not idle after reset");

    run_insn("mlogic_vl200", MLOGIC, EW8, 1'b1, 200, 3'd1);
    run_insn("merge_ew8_tail", MERGE, EW8, 1'b1, 37, 3'd2);
    run_insn("merge_ew16_tail", MERGE, EW16, 1'b1, 23, 3'd3);
    run_insn("merge_ew32_tail", MERGE, EW32, 1'b1, 11, 3'd4);
    run_insn("merge_ew64_tail", MERGE, EW64, 1'b1, 5, 3'd5);
    run_insn("merge_masked_ew8", MERGE, EW8, 1'b0, 200, 3'd6);
    // Result channel stalls from here on
    bp_on <= 1'b1;
    run_insn("stall_ew32", MERGE, EW32, 1'b1, 45, 3'd7);
    run_insn("stall_masked_ew16", MERGE, EW16, 1'b0, 150, 3'd0);
    run_insn("stall_mlogic", MLOGIC, EW8, 1'b1, 300, 3'd2);
    finish_run();
  end

endmodule

`default_nettype wire

// File: masku.f
masku_pkg.sv
masku_beat_if.sv
masku_ctrl.sv
masku_tail_gen.sv
masku_predicate_expand.sv
masku_blend.sv
masku.sv
tb_masku.sv

// File: Bender.yml
package:
  name: masku

sources:
  - masku_pkg.sv
  - masku_beat_if.sv
  - masku_ctrl.sv
  - masku_tail_gen.sv
  - masku_predicate_expand.sv
  - masku_blend.sv
  - masku.sv
  - target: test
    files:
      - tb_masku.sv
